//--- ddc.f
verilog/ddc_pkg.sv
verilog/ddc_settings.sv
verilog/ddc_input_mux.sv
verilog/cordic_mixer.sv
verilog/cic_decimator.sv
verilog/ddc_output_scaler.sv
verilog/ddc.sv
sim/ddc_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the ddc testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module ddc_tb -f ddc.f
./obj_dir/Vddc_tb | tee sim.log
grep -qx "Testbench passed" sim.log

//--- sim/ddc_tb.sv
// ddc testbench
// drives settings and samples on the falling edge, concurrent assertions check the outputs
// expected values come from the CORDIC gain, the scale and the CIC rate
`timescale 1ns/1ps
`default_nettype none

module ddc_tb;

  localparam int  BASE        = 'h40;
  localparam int  MAX_RATE    = 255;
  localparam int  CLK_PERIOD  = 40;
  localparam int  IW          = ddc_pkg::IO_W;
  localparam int  DRAIN       = 40;  // input to output latency is 32 cycles
  localparam int  SETUP       = 20;
  localparam int  SETTLE      = 6;   // outputs skipped while the CIC fills
  localparam int  VAL_SAMPLES = 96;
  localparam int  MAG_SAMPLES = 24;
  localparam int  UNITY       = 16384;
  localparam real CORDIC_GAIN = 1.6468;
  localparam int  TEST_CYCLES = 10 + 60 + 3 * (SETUP + 23 + DRAIN)
                              + 4 * (SETUP + VAL_SAMPLES + 2 * DRAIN)
                              + (SETUP + MAG_SAMPLES + 2 * DRAIN)
                              + 2 * (SETUP + 42 + DRAIN);

  logic        clk;
  logic        reset;
  logic        i_clear;
  logic        i_set_stb;
  logic [7:0]  i_set_addr;
  logic [31:0] i_set_data;
  logic        i_sample_in_stb;
  logic [31:0] i_sample_in;
  logic        o_sample_out_stb;
  logic [31:0] o_sample_out;

  logic [31:0] lfsr;
  int          errors;
  int          tests_run;
  int          tests_failed;
  int          out_count;  // output strobes since the last clear
  logic        idle_chk;
  logic        count_chk;
  logic        val_chk;
  logic        mag_chk;
  int          exp_count;
  int          exp_i;
  int          exp_q;
  int          tol_i;
  int          tol_q;
  longint      exp_mag;
  longint      tol_mag;

  ddc #(.BASE(BASE), .MAX_RATE(MAX_RATE)) i_dut (
    .clk(clk), .reset(reset), .i_clear(i_clear),
    .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
    .i_sample_in_stb(i_sample_in_stb), .i_sample_in(i_sample_in),
    .o_sample_out_stb(o_sample_out_stb), .o_sample_out(o_sample_out));

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    repeat (4 * TEST_CYCLES) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", 4 * TEST_CYCLES);
    $display("Testbench failed");
    $finish;
  end

  always @(posedge clk) begin
    if (reset || i_clear) begin
      out_count <= 0;
    end else if (o_sample_out_stb) begin
      out_count <= out_count + 1;
    end
  end

  // galois form, taps 32 31 29 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
  endfunction

  function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int b = 0; b < n; b++) begin
      lfsr = lfsr_next(lfsr);
      v = (v << 1) | int'(lfsr[0]);
    end
    return v;
  endfunction

  // magnitude 4096..8191 keeps the CORDIC clear of its guard bit
  function automatic int rand_component();
    int mag;
    mag = 4096 + take_bits(12);
    return (take_bits(1) != 0) ? -mag : mag;
  endfunction

  function automatic int predict(input int v, input int scale);
    real r;
    r = $itor(v) * CORDIC_GAIN * $itor(scale) / 16384.0;
    if (r > 32767.0) begin
      return 32767;
    end
    if (r < -32767.0) begin
      return -32767;
    end
    return (r < 0.0) ? -$rtoi(0.5 - r) : $rtoi(r + 0.5);
  endfunction

  function automatic int tol_of(input int e);
    return ((e < 0) ? -e : e) / 100 + 2;  // 1% plus 2 LSB
  endfunction

  function automatic bit close(input longint got, input longint expected, input longint tol);
    return (got - expected <= tol) && (expected - got <= tol);
  endfunction

  function automatic int upper_of(input logic [31:0] w);
    return int'($signed(w[31:16]));
  endfunction

  function automatic int lower_of(input logic [31:0] w);
    return int'($signed(w[15:0]));
  endfunction

  function automatic longint power_of(input logic [31:0] w);
    longint i;
    longint q;
    i = longint'(upper_of(w));
    q = longint'(lower_of(w));
    return i * i + q * q;
  endfunction

  a_idle: assert property (@(posedge clk) disable iff (reset)
      idle_chk |-> !o_sample_out_stb)
    else begin
      errors = errors + 1;
      $display("output strobe seen without any input samples at %0t", $time);
    end

  a_count: assert property (@(posedge clk) disable iff (reset)
      count_chk |-> out_count == exp_count)
    else begin
      errors = errors + 1;
      $display("FAIL out_count: got %h expected %h", $sampled(out_count), $sampled(exp_count));
    end

  a_out_i: assert property (@(posedge clk) disable iff (reset)
      (o_sample_out_stb && val_chk && out_count >= SETTLE)
      |-> close(upper_of(o_sample_out), exp_i, tol_i))
    else begin
      errors = errors + 1;
      $display("FAIL o_sample_out[31:16]: got %h expected %h",
               upper_of($sampled(o_sample_out)), $sampled(exp_i));
    end

  a_out_q: assert property (@(posedge clk) disable iff (reset)
      (o_sample_out_stb && val_chk && out_count >= SETTLE)
      |-> close(lower_of(o_sample_out), exp_q, tol_q))
    else begin
      errors = errors + 1;
      $display("FAIL o_sample_out[15:0]: got %h expected %h",
               lower_of($sampled(o_sample_out)), $sampled(exp_q));
    end

  a_mag: assert property (@(posedge clk) disable iff (reset)
      (o_sample_out_stb && mag_chk && out_count >= SETTLE)
      |-> close(power_of(o_sample_out), exp_mag, tol_mag))
    else begin
      errors = errors + 1;
      $display("FAIL o_sample_out I^2+Q^2: got %h expected %h",
               power_of($sampled(o_sample_out)), $sampled(exp_mag));
    end

  task automatic idle(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic write_reg(input int offset, input logic [31:0] data);
    @(negedge clk);
    i_set_stb  = 1'b1;
    i_set_addr = 8'(BASE + offset);
    i_set_data = data;
    @(negedge clk);
    i_set_stb = 1'b0;
  endtask

  task automatic clear_dp();
    @(negedge clk);
    i_clear = 1'b1;
    @(negedge clk);
    i_clear = 1'b0;
  endtask

  // clear first so the rate write is applied at once
  task automatic configure(input int rate, input int scale, input logic [31:0] phase_inc,
                           input logic [31:0] mode);
    clear_dp();
    write_reg(ddc_pkg::ADDR_RATE, 32'(rate));
    write_reg(ddc_pkg::ADDR_SCALE, 32'(scale));
    write_reg(ddc_pkg::ADDR_PHASE_INC, phase_inc);
    write_reg(ddc_pkg::ADDR_MODE, mode);
    idle(4);
  endtask

  task automatic send_samples(input int n, input logic [31:0] word);
    repeat (n) begin
      @(negedge clk);
      i_sample_in_stb = 1'b1;
      i_sample_in     = word;
    end
    @(negedge clk);
    i_sample_in_stb = 1'b0;
  endtask

  task automatic wait_outputs(input int n);
    int cycles;
    cycles = 0;
    while (out_count < n && cycles < 2 * DRAIN) begin
      @(negedge clk);
      cycles++;
    end
    if (out_count < n) begin
      errors++;
      $display("timeout: only %0d of %0d output strobes arrived", out_count, n);
    end
  endtask

  task automatic check_count(input int expected);
    idle(DRAIN);
    exp_count = expected;
    count_chk = 1'b1;
    @(negedge clk);
    count_chk = 1'b0;
  endtask

  task automatic count_run(input int rate, input int k);
    configure(rate, UNITY, 32'h0, 32'h0);
    send_samples(k, 32'h1000_2000);
    check_count(k / rate);
  endtask

  task automatic value_run(input int scale, input bit swap, input bit realm);
    int          vi;
    int          vq;
    logic [31:0] mode;
    vi   = rand_component();
    vq   = rand_component();
    mode = (32'(swap) << ddc_pkg::MODE_SWAP_BIT) | (32'(realm) << ddc_pkg::MODE_REAL_BIT);
    configure(8, scale, 32'h0, mode);
    exp_i = predict(swap ? vq : vi, scale);
    exp_q = realm ? 0 : predict(swap ? vi : vq, scale);  // real mode zeros Q after the swap
    tol_i = tol_of(exp_i);
    tol_q = realm ? 1 : tol_of(exp_q);
    val_chk = 1'b1;
    send_samples(VAL_SAMPLES, {IW'(vi), IW'(vq)});
    wait_outputs(VAL_SAMPLES / 8);
    val_chk = 1'b0;
  endtask

  task automatic rotation_run();
    int  vi;
    int  vq;
    real r;
    vi = rand_component();
    vq = rand_component();
    configure(1, UNITY, 32'h4000_0000, 32'h0);  // quarter turn per sample
    r = ($itor(vi) * $itor(vi) + $itor(vq) * $itor(vq)) * CORDIC_GAIN * CORDIC_GAIN;
    exp_mag = longint'($rtoi(r));
    tol_mag = exp_mag / 50;
    mag_chk = 1'b1;
    send_samples(MAG_SAMPLES, {IW'(vi), IW'(vq)});
    wait_outputs(MAG_SAMPLES);
    mag_chk = 1'b0;
  endtask

  task automatic report(input int num, input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", num, name, errors - errors_before);
    end
  endtask

  initial begin
    int base_err;
    reset           = 1'b1;
    i_clear         = 1'b0;
    i_set_stb       = 1'b0;
    i_set_addr      = 8'h00;
    i_set_data      = 32'h0;
    i_sample_in_stb = 1'b0;
    i_sample_in     = 32'h0;
    idle_chk        = 1'b0;
    count_chk       = 1'b0;
    val_chk         = 1'b0;
    mag_chk         = 1'b0;
    lfsr            = 32'he2fa_f8a4;
    errors          = 0;
    tests_run       = 0;
    tests_failed    = 0;
    repeat (10) @(negedge clk);
    reset = 1'b0;

    base_err = errors;
    idle_chk = 1'b1;
    idle(60);
    idle_chk = 1'b0;
    report(1, "idle after reset", base_err);

    base_err = errors;
    count_run(1, 13);
    count_run(4, 23);
    count_run(5, 23);
    report(2, "decimation counts", base_err);

    base_err = errors;
    value_run(UNITY, 1'b0, 1'b0);
    value_run(18'h3FFFF, 1'b0, 1'b0);  // large scale saturates both components
    report(3, "constant input level", base_err);

    base_err = errors;
    value_run(UNITY, 1'b0, 1'b1);
    value_run(UNITY, 1'b1, 1'b0);
    report(4, "real and swap modes", base_err);

    base_err = errors;
    rotation_run();
    report(5, "NCO rotation magnitude", base_err);

    // rate 5 written mid-stream must wait for the clear
    base_err = errors;
    configure(4, UNITY, 32'h0, 32'h0);
    fork
      send_samples(42, 32'h1000_2000);
      begin
        idle(20);
        write_reg(ddc_pkg::ADDR_RATE, 32'd5);
      end
    join
    check_count(10);
    clear_dp();
    idle(4);
    send_samples(40, 32'h1000_2000);
    check_count(8);
    report(6, "held rate change", base_err);

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/ddc.sv
// ddc top
// settings, input mux, CORDIC mixer, I/Q CIC decimators and output scaler
`timescale 1ns/1ps
`default_nettype none

module ddc #(
  parameter int BASE     = 0,
  parameter int MAX_RATE = 255
) (
  input  wire                         clk,
  input  wire                         reset,
  input  wire                         i_clear,
  input  wire                         i_set_stb,
  input  wire  [7:0]                  i_set_addr,
  input  wire  [31:0]                 i_set_data,
  input  wire                         i_sample_in_stb,
  input  wire  [2*ddc_pkg::IO_W-1:0]  i_sample_in,
  output logic                        o_sample_out_stb,
  output logic [2*ddc_pkg::IO_W-1:0]  o_sample_out
);

  localparam int SW = ddc_pkg::SAMPLE_W;

  logic [ddc_pkg::PHASE_W-1:0] phase_inc;
  logic [ddc_pkg::SCALE_W-1:0] scale;
  logic [ddc_pkg::RATE_W-1:0]  rate;
  logic                        rate_stb;
  logic                        swap_iq;
  logic                        real_mode;
  logic                        mux_stb, mix_stb, cic_stb;
  logic [SW-1:0]               mux_i, mux_q;
  logic [SW-1:0]               mix_i, mix_q;
  logic [SW-1:0]               cic_i, cic_q;

  ddc_settings #(.BASE(BASE)) u_settings (
    .clk(clk), .reset(reset), .i_clear(i_clear),
    .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
    .i_sample_in_stb(i_sample_in_stb),
    .o_phase_inc(phase_inc), .o_scale(scale), .o_rate(rate), .o_rate_stb(rate_stb),
    .o_swap_iq(swap_iq), .o_real_mode(real_mode));

  ddc_input_mux u_input_mux (
    .clk(clk), .reset(reset), .i_clear(i_clear),
    .i_sample_in_stb(i_sample_in_stb), .i_sample_in(i_sample_in),
    .i_swap_iq(swap_iq), .i_real_mode(real_mode),
    .o_stb(mux_stb), .o_i(mux_i), .o_q(mux_q));

  cordic_mixer u_mixer (
    .clk(clk), .reset(reset), .i_clear(i_clear),
    .i_stb(mux_stb), .i_i(mux_i), .i_q(mux_q), .i_phase_inc(phase_inc),
    .o_stb(mix_stb), .o_i(mix_i), .o_q(mix_q));

  cic_decimator #(.MAX_RATE(MAX_RATE)) u_cic_i (
    .clk(clk), .reset(reset), .i_clear(i_clear),
    .i_rate(rate), .i_rate_stb(rate_stb),
    .i_stb(mix_stb), .i_data(mix_i), .o_stb(cic_stb), .o_data(cic_i));

  cic_decimator #(.MAX_RATE(MAX_RATE)) u_cic_q (
    .clk(clk), .reset(reset), .i_clear(i_clear),
    .i_rate(rate), .i_rate_stb(rate_stb),
    .i_stb(mix_stb), .i_data(mix_q), .o_stb(), .o_data(cic_q));  // strobe matches u_cic_i

  ddc_output_scaler u_scaler (
    .clk(clk), .reset(reset), .i_clear(i_clear),
    .i_stb(cic_stb), .i_i(cic_i), .i_q(cic_q), .i_scale(scale),
    .o_stb(o_sample_out_stb), .o_sample_out(o_sample_out));

endmodule

`default_nettype wire

//--- verilog/ddc_output_scaler.sv
// ddc output scaler
// scale multiply, clip to 24 bits, round half away from zero to the 16-bit I/Q word
`timescale 1ns/1ps
`default_nettype none

module ddc_output_scaler (
  input  wire                                 clk,
  input  wire                                 reset,
  input  wire                                 i_clear,
  input  wire                                 i_stb,
  input  wire  signed [ddc_pkg::SAMPLE_W-1:0] i_i,
  input  wire  signed [ddc_pkg::SAMPLE_W-1:0] i_q,
  input  wire         [ddc_pkg::SCALE_W-1:0]  i_scale,
  output logic                                o_stb,
  output logic        [2*ddc_pkg::IO_W-1:0]   o_sample_out
);

  localparam int SW     = ddc_pkg::SAMPLE_W;
  localparam int IW     = ddc_pkg::IO_W;
  localparam int PROD_W = SW + 1 + ddc_pkg::SCALE_W;  // 25 x 18 product
  localparam int LSB    = 14;                        // scale of 2^14 is unity
  localparam int KEEP_W = PROD_W - LSB;
  localparam int DROP   = SW - IW;

  localparam logic signed [SW:0] HALF    = (SW+1)'(2 ** (DROP - 1));
  localparam logic signed [SW:0] HALF_M1 = (SW+1)'(2 ** (DROP - 1) - 1);

  logic signed [SW-1:0]     i_r, q_r;
  logic signed [PROD_W-1:0] i_prod, q_prod;
  logic signed [SW-1:0]     i_clip, q_clip;
  logic [3:0]               stb_pipe;

  function automatic logic [SW-1:0] sat(input logic signed [PROD_W-1:0] p);
    logic signed [KEEP_W-1:0] v;
    v = p[PROD_W-1:LSB];
    if ((v[KEEP_W-1:SW-1] == '0) || (v[KEEP_W-1:SW-1] == '1)) begin
      sat = v[SW-1:0];
    end else begin
      sat = {v[KEEP_W-1], {(SW-1){~v[KEEP_W-1]}}};
    end
  endfunction

  // half away from zero, saturating at the top
  function automatic logic [IW-1:0] round(input logic signed [SW-1:0] v);
    logic signed [SW:0] sum;
    sum = (SW+1)'(v) + (v[SW-1] ? HALF_M1 : HALF);
    if (sum[SW] != sum[SW-1]) begin
      round = {sum[SW], {(IW-1){~sum[SW]}}};
    end else begin
      round = sum[SW-1:DROP];
    end
  endfunction

  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      stb_pipe <= '0;
    end else begin
      stb_pipe <= {stb_pipe[2:0], i_stb};
    end
  end

  assign o_stb = stb_pipe[3];

  always_ff @(posedge clk) begin
    i_r    <= i_i;
    q_r    <= i_q;
    i_prod <= PROD_W'(i_r) * PROD_W'($signed({1'b0, i_scale}));  // unsigned scale
    q_prod <= PROD_W'(q_r) * PROD_W'($signed({1'b0, i_scale}));
    i_clip <= sat(i_prod);
    q_clip <= sat(q_prod);
    o_sample_out <= {round(i_clip), round(q_clip)};  // I in the upper half
  end

endmodule

`default_nettype wire

//--- verilog/cic_decimator.sv
// cic decimator
// fourth-order CIC with a runtime rate and an output shift of order * ceil(log2 rate)
`timescale 1ns/1ps
`default_nettype none

module cic_decimator #(
  parameter int MAX_RATE = 255
) (
  input  wire                                 clk,
  input  wire                                 reset,
  input  wire                                 i_clear,
  input  wire         [ddc_pkg::RATE_W-1:0]   i_rate,
  input  wire                                 i_rate_stb,
  input  wire                                 i_stb,
  input  wire  signed [ddc_pkg::SAMPLE_W-1:0] i_data,
  output logic                                o_stb,
  output logic signed [ddc_pkg::SAMPLE_W-1:0] o_data
);

  localparam int N       = ddc_pkg::CIC_ORDER;
  localparam int SW      = ddc_pkg::SAMPLE_W;
  localparam int RW      = ddc_pkg::RATE_W;
  localparam int ACC_W   = SW + N * $clog2(MAX_RATE + 1);  // worst case growth
  localparam int SHIFT_W = $clog2(N * RW + 1);

  logic signed [ACC_W-1:0] integ    [0:N-1];
  logic signed [ACC_W-1:0] comb_dly [0:N-1];
  logic signed [ACC_W-1:0] comb_in  [0:N];  // comb_in[N] is the comb output
  logic [RW-1:0]      cnt;
  logic [SHIFT_W-1:0] shift;
  logic               decim;

  // shift = N * ceil(log2 rate)
  always_comb begin
    shift = '0;
    for (int b = 0; b < RW; b++) begin
      if ((RW'(1) << b) < i_rate) begin
        shift = SHIFT_W'(N * (b + 1));
      end
    end
  end

  always_comb begin
    comb_in[0] = integ[N-1];
    for (int k = 0; k < N; k++) begin
      comb_in[k+1] = comb_in[k] - comb_dly[k];
    end
  end

  assign decim = i_stb && (cnt == i_rate - RW'(1));  // rate-th input

  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      for (int k = 0; k < N; k++) begin
        integ[k]    <= '0;
        comb_dly[k] <= '0;
      end
      cnt   <= '0;
      o_stb <= 1'b0;
    end else begin
      o_stb <= decim;
      if (i_rate_stb) begin
        cnt <= '0;  // restart on a new rate
      end else if (i_stb) begin
        cnt <= decim ? '0 : cnt + RW'(1);
      end
      if (i_stb) begin
        integ[0] <= integ[0] + ACC_W'(i_data);
        for (int k = 1; k < N; k++) begin
          integ[k] <= integ[k] + integ[k-1];
        end
      end
      if (decim) begin
        for (int k = 0; k < N; k++) begin
          comb_dly[k] <= comb_in[k];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (decim) begin
      o_data <= SW'(comb_in[N] >>> shift);
    end
  end

  a_rate_max: assert property (@(posedge clk) disable iff (reset)
      (i_rate != '0) && (int'(i_rate) <= MAX_RATE));

endmodule

`default_nettype wire

//--- verilog/cordic_mixer.sv
// cordic mixer
// NCO phase accumulator driving a pipelined CORDIC rotator, clipped back to 24 bits
// gain is the CORDIC constant of about 1.6468
`timescale 1ns/1ps
`default_nettype none

module cordic_mixer (
  input  wire                           clk,
  input  wire                           reset,
  input  wire                           i_clear,
  input  wire                           i_stb,
  input  wire  [ddc_pkg::SAMPLE_W-1:0]  i_i,
  input  wire  [ddc_pkg::SAMPLE_W-1:0]  i_q,
  input  wire  [ddc_pkg::PHASE_W-1:0]   i_phase_inc,
  output logic                          o_stb,
  output logic [ddc_pkg::SAMPLE_W-1:0]  o_i,
  output logic [ddc_pkg::SAMPLE_W-1:0]  o_q
);

  localparam int SW     = ddc_pkg::SAMPLE_W;
  localparam int CW     = ddc_pkg::CORDIC_W;
  localparam int ZW     = ddc_pkg::ZETA_W;
  localparam int PW     = ddc_pkg::PHASE_W;
  localparam int STAGES = ddc_pkg::SAMPLE_W;

  logic        [PW-1:0] phase;
  logic        [ZW-1:0] zeta;
  logic signed [CW-1:0] x_ext;
  logic signed [CW-1:0] y_ext;
  logic signed [CW-1:0] x_pipe [0:STAGES];
  logic signed [CW-1:0] y_pipe [0:STAGES];
  logic signed [ZW-1:0] z_pipe [0:STAGES-1];
  logic        [STAGES:0] stb_pipe;  // strobes in flight with the data

  // atan(2^-k) with pi at 2^(ZW-1)
  function automatic logic signed [ZW-1:0] atan_lut(input int k);
    case (k)
      0:  atan_lut = ZW'(2097152);
      1:  atan_lut = ZW'(1238021);
      2:  atan_lut = ZW'(654136);
      3:  atan_lut = ZW'(332050);
      4:  atan_lut = ZW'(166669);
      5:  atan_lut = ZW'(83416);
      6:  atan_lut = ZW'(41718);
      7:  atan_lut = ZW'(20860);
      8:  atan_lut = ZW'(10430);
      9:  atan_lut = ZW'(5215);
      10: atan_lut = ZW'(2608);
      11: atan_lut = ZW'(1304);
      12: atan_lut = ZW'(652);
      13: atan_lut = ZW'(326);
      14: atan_lut = ZW'(163);
      15: atan_lut = ZW'(81);
      16: atan_lut = ZW'(41);
      17: atan_lut = ZW'(20);
      18: atan_lut = ZW'(10);
      19: atan_lut = ZW'(5);
      20: atan_lut = ZW'(3);
      21: atan_lut = ZW'(1);
      22: atan_lut = ZW'(1);
      default: atan_lut = '0;
    endcase
  endfunction

  function automatic logic [SW-1:0] clip(input logic signed [CW-1:0] v);
    if (v[CW-1] != v[CW-2]) begin
      clip = {v[CW-1], {(SW-1){~v[CW-1]}}};
    end else begin
      clip = v[SW-1:0];
    end
  endfunction

  assign zeta  = phase[PW-1 -: ZW];
  assign x_ext = CW'($signed(i_i));
  assign y_ext = CW'($signed(i_q));

  // input register with quadrant pre-rotation
  always_ff @(posedge clk) begin
    if (zeta[ZW-1] ^ zeta[ZW-2]) begin  // beyond +-90 degrees so rotate by 180
      x_pipe[0] <= -x_ext;
      y_pipe[0] <= -y_ext;
      z_pipe[0] <= {~zeta[ZW-1], zeta[ZW-2:0]};
    end else begin
      x_pipe[0] <= x_ext;
      y_pipe[0] <= y_ext;
      z_pipe[0] <= zeta;
    end
  end

  for (genvar k = 0; k < STAGES; k++) begin : g_stage
    always_ff @(posedge clk) begin
      if (z_pipe[k][ZW-1]) begin
        x_pipe[k+1] <= x_pipe[k] + (y_pipe[k] >>> k);
        y_pipe[k+1] <= y_pipe[k] - (x_pipe[k] >>> k);
      end else begin
        x_pipe[k+1] <= x_pipe[k] - (y_pipe[k] >>> k);
        y_pipe[k+1] <= y_pipe[k] + (x_pipe[k] >>> k);
      end
    end
    if (k < STAGES - 1) begin : g_zeta
      always_ff @(posedge clk) begin
        z_pipe[k+1] <= z_pipe[k][ZW-1] ? z_pipe[k] + atan_lut(k) : z_pipe[k] - atan_lut(k);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      phase    <= '0;
      stb_pipe <= '0;
      o_stb    <= 1'b0;
    end else begin
      if (i_stb) begin
        phase <= phase + i_phase_inc;  // next sample sees the advanced phase
      end
      stb_pipe <= {stb_pipe[STAGES-1:0], i_stb};
      o_stb    <= stb_pipe[STAGES];
    end
  end

  always_ff @(posedge clk) begin
    o_i <= clip(x_pipe[STAGES]);
    o_q <= clip(y_pipe[STAGES]);
  end

  // the rotation drives the residual angle close to zero
  a_angle_converged: assert property (@(posedge clk) disable iff (reset)
      stb_pipe[STAGES-1] |-> (z_pipe[STAGES-1] < 64) && (z_pipe[STAGES-1] > -64));

endmodule

`default_nettype wire

//--- verilog/ddc_input_mux.sv
// ddc input mux
// unpacks the I/Q word to 24 bits, applies I/Q swap and real mode
`timescale 1ns/1ps
`default_nettype none

module ddc_input_mux (
  input  wire                           clk,
  input  wire                           reset,
  input  wire                           i_clear,
  input  wire                           i_sample_in_stb,
  input  wire  [2*ddc_pkg::IO_W-1:0]    i_sample_in,
  input  wire                           i_swap_iq,
  input  wire                           i_real_mode,
  output logic                          o_stb,
  output logic [ddc_pkg::SAMPLE_W-1:0]  o_i,
  output logic [ddc_pkg::SAMPLE_W-1:0]  o_q
);

  localparam int SW = ddc_pkg::SAMPLE_W;
  localparam int IW = ddc_pkg::IO_W;

  logic [SW-1:0] in_i;
  logic [SW-1:0] in_q;

  assign in_i = {i_sample_in[2*IW-1 -: IW], {(SW-IW){1'b0}}};  // I in the upper half
  assign in_q = {i_sample_in[IW-1:0], {(SW-IW){1'b0}}};

  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      o_stb <= 1'b0;
      o_i   <= '0;
      o_q   <= '0;
    end else begin
      o_stb <= i_sample_in_stb;
      o_i   <= i_swap_iq ? in_q : in_i;
      o_q   <= i_real_mode ? '0 : (i_swap_iq ? in_i : in_q);  // real mode zeros Q after the swap
    end
  end

endmodule

`default_nettype wire

//--- verilog/ddc_settings.sv
// ddc settings registers
// address-decoded config registers; a rate change is held back while samples flow
`timescale 1ns/1ps
`default_nettype none

module ddc_settings #(
  parameter int BASE = 0
) (
  input  wire                          clk,
  input  wire                          reset,
  input  wire                          i_clear,
  input  wire                          i_set_stb,
  input  wire  [7:0]                   i_set_addr,
  input  wire  [31:0]                  i_set_data,
  input  wire                          i_sample_in_stb,
  output logic [ddc_pkg::PHASE_W-1:0]  o_phase_inc,
  output logic [ddc_pkg::SCALE_W-1:0]  o_scale,
  output logic [ddc_pkg::RATE_W-1:0]   o_rate,
  output logic                         o_rate_stb,
  output logic                         o_swap_iq,
  output logic                         o_real_mode
);

  localparam int RW = ddc_pkg::RATE_W;

  logic [RW-1:0] rate_req;  // rate as last written on the bus
  logic          rate_wr;   // rate register written last cycle
  logic          active;    // samples seen since the last clear
  logic          rate_pend;

  always_ff @(posedge clk) begin
    if (reset) begin
      o_phase_inc <= '0;
      o_scale     <= '0;
      o_swap_iq   <= 1'b0;
      o_real_mode <= 1'b0;
      rate_req    <= RW'(1);  // no decimation
      rate_wr     <= 1'b0;
    end else begin
      rate_wr <= 1'b0;
      if (i_set_stb) begin
        case (i_set_addr)
          8'(BASE + ddc_pkg::ADDR_PHASE_INC): o_phase_inc <= i_set_data;
          8'(BASE + ddc_pkg::ADDR_SCALE):     o_scale <= i_set_data[ddc_pkg::SCALE_W-1:0];
          8'(BASE + ddc_pkg::ADDR_RATE): begin
            rate_req <= i_set_data[RW-1:0];
            rate_wr  <= 1'b1;
          end
          8'(BASE + ddc_pkg::ADDR_MODE): begin
            o_swap_iq   <= i_set_data[ddc_pkg::MODE_SWAP_BIT];
            o_real_mode <= i_set_data[ddc_pkg::MODE_REAL_BIT];
          end
          default: ;
        endcase
      end
    end
  end

  // changing the CIC rate mid-stream would corrupt its state
  always_ff @(posedge clk) begin
    if (reset) begin
      active     <= 1'b0;
      rate_pend  <= 1'b0;
      o_rate     <= RW'(1);
      o_rate_stb <= 1'b0;
    end else begin
      if (i_clear) begin
        active <= 1'b0;
      end else if (i_sample_in_stb) begin
        active <= 1'b1;
      end
      o_rate_stb <= 1'b0;
      if (rate_wr && active) begin
        rate_pend <= 1'b1;  // apply after the next clear
      end
      if (!active && (rate_wr || rate_pend)) begin
        rate_pend  <= 1'b0;
        o_rate     <= rate_req;
        o_rate_stb <= 1'b1;
      end
    end
  end

  a_rate_nonzero: assert property (@(posedge clk) disable iff (reset) o_rate != '0);

endmodule

`default_nettype wire

//--- verilog/ddc_pkg.sv
// ddc shared definitions
// sample widths, settings register map and mode register layout
`default_nettype none

package ddc_pkg;

  // datapath widths
  localparam int SAMPLE_W = 24;  // internal I/Q width
  localparam int IO_W     = 16;  // one component of the input/output word
  localparam int CORDIC_W = 25;  // one guard bit for CORDIC growth
  localparam int PHASE_W  = 32;  // NCO accumulator
  localparam int ZETA_W   = 24;  // phase bits into the rotator
  localparam int SCALE_W  = 18;  // unsigned output scale, 2^14 is unity
  localparam int RATE_W   = 8;   // CIC decimation rate

  localparam int CIC_ORDER = 4;

  // settings register offsets from BASE
  localparam int ADDR_PHASE_INC = 0;
  localparam int ADDR_SCALE     = 1;
  localparam int ADDR_RATE      = 2;
  localparam int ADDR_MODE      = 3;

  // mode register bits
  localparam int MODE_SWAP_BIT = 0;
  localparam int MODE_REAL_BIT = 1;

endpackage

`default_nettype wire
